//--- vlog.f
src/decode_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/decode_stage.sv
tests/decode_properties.sv
tests/tb_decode_stage.sv

//--- tests/tb_decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int N_RAND      = 400;
    localparam int STIM_CYCLES = 40 + 80 * 8 + N_RAND;

    logic           clk = 1'b0;
    logic           reset;
    logic           fs_to_ds_valid;
    fetch_bundle_t  fs_to_ds;
    logic           ds_allowin;
    logic           es_allowin;
    fwd_bus_t       es_fwd;
    fwd_bus_t       ms_fwd;
    fwd_bus_t       ws_fwd;
    rf_write_t      rf_write;
    logic           ds_to_es_valid;
    decode_bundle_t ds_to_es;
    branch_bus_t    br;
    integer         seed;
    logic [31:0]    kept [$];

    bind decode_stage decode_properties props0 (.*);

    decode_stage dut0 (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] r_word(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                           reg_addr_t rd, logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fwd_bus_t rand_bus();
        logic [31:0] r;
        r = $random(seed);
        // small address range so matches happen often
        return '{valid: r[0], we: r[1], is_load: r[3:2] == 2'd0, addr: {2'b00, r[6:4]},
                 value: $random(seed)};
    endfunction

    task automatic issue(input logic [31:0] word, input logic [31:0] pc);
        int   waited;
        logic accepted;
        waited = 0;
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds       <= {pc, word};
        do begin
            @(negedge clk);
            accepted = ds_allowin;
            @(posedge clk);
            waited++;
        end while (!accepted && waited < 50);
        fs_to_ds_valid <= 1'b0;
        if (!accepted) begin
            $display("Errors found");
            $fatal(1, "decode stage never accepted an instruction");
        end
    endtask

    task automatic build_kept();
        logic [5:0] fns [16] = '{FN_ADDU, FN_SUBU, FN_ADD, FN_SUB, FN_SLT, FN_SLTU, FN_AND,
                                 FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV,
                                 FN_SLL, FN_SRL, FN_SRA};
        logic [5:0] ops [9] = '{OP_ADDIU, OP_ADDI, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                OP_XORI, OP_LW, OP_SW};
        for (int i = 0; i < 13; i++) kept.push_back(r_word(fns[i], 5'd1, 5'd2, 5'd3, 5'd0));
        for (int i = 13; i < 16; i++) kept.push_back(r_word(fns[i], 5'd0, 5'd2, 5'd3, 5'd5));
        for (int i = 0; i < 9; i++) kept.push_back(i_word(ops[i], 5'd1, 5'd4, 16'h8004));
        kept.push_back(i_word(OP_LUI, 5'd0, 5'd4, 16'h1234));
        kept.push_back(i_word(OP_BEQ, 5'd1, 5'd1, 16'hfffc));
        kept.push_back(i_word(OP_BNE, 5'd1, 5'd2, 16'h0010));
        kept.push_back(i_word(OP_REGIMM, 5'd2, RT_BGEZ, 16'h0020));
        kept.push_back(i_word(OP_BGTZ, 5'd2, 5'd0, 16'h0030));
        kept.push_back(i_word(OP_BLEZ, 5'd1, 5'd0, 16'hff00));
        kept.push_back(i_word(OP_REGIMM, 5'd1, RT_BLTZ, 16'h0040));
        kept.push_back({OP_J, 26'h0123456});
        kept.push_back({OP_JAL, 26'h2abcdef});
        kept.push_back(r_word(FN_JR, 5'd2, 5'd0, 5'd0, 5'd0));
        kept.push_back(r_word(FN_JALR, 5'd2, 5'd0, 5'd31, 5'd0));
        kept.push_back({OP_SPECIAL, 20'h12345, FN_SYSCALL});
        kept.push_back({OP_SPECIAL, 20'h00000, FN_BREAK});
    endtask

    initial begin
        #(STIM_CYCLES * 40 + 2000);
        $display("Errors found");
        $fatal(1, "run timed out");
    end

    initial begin
        forever begin
            @(negedge clk);
            if (dut0.props0.fail_count != 0) begin
                $display("Errors found");
                $fatal(1, "checker reported a failing assertion");
            end
        end
    end

    initial begin
        seed = 45;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        rf_write = '0;
        build_kept();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // odd registers negative, even ones positive
        for (int i = 1; i < 32; i++) begin
            @(posedge clk);
            rf_write <= '{we: 1'b1, addr: i[4:0],
                          data: (i * 32'h0101_0101) ^ (i[0] ? 32'h8000_0000 : 32'd0)};
        end
        @(posedge clk);
        rf_write <= '0;

        foreach (kept[i]) issue(kept[i], 32'h0040_0000 + i * 4);
        issue(32'hfc00_0000, 32'h0040_1000);
        issue(32'h0000_0001, 32'h0040_1004);
        issue(32'h4000_0000, 32'h0040_1008);
        issue(r_word(FN_SLL, 5'd1, 5'd2, 5'd3, 5'd4), 32'h0040_100c);
        issue(32'h0000_0000, 32'h0040_1010);

        // priority among execute, memory and writeback
        es_fwd <= '{1'b1, 1'b1, 1'b0, 5'd3, 32'haaaa_0003};
        ms_fwd <= '{1'b1, 1'b1, 1'b0, 5'd4, 32'hbbbb_0004};
        ws_fwd <= '{1'b1, 1'b1, 1'b0, 5'd4, 32'hcccc_0004};
        issue(r_word(FN_ADDU, 5'd3, 5'd4, 5'd6, 5'd0), 32'h0040_2000);
        ms_fwd <= '{1'b1, 1'b1, 1'b0, 5'd3, 32'hbbbb_0003};
        ws_fwd <= '{1'b1, 1'b1, 1'b0, 5'd5, 32'hcccc_0005};
        issue(r_word(FN_ADDU, 5'd3, 5'd5, 5'd6, 5'd0), 32'h0040_2004);
        es_fwd <= '{1'b0, 1'b1, 1'b0, 5'd3, 32'haaaa_0003};
        issue(i_word(OP_BEQ, 5'd3, 5'd5, 16'h0004), 32'h0040_2008);
        es_fwd <= '{1'b1, 1'b1, 1'b1, 5'd7, 32'hdead_beef};
        issue(r_word(FN_ADDU, 5'd7, 5'd0, 5'd8, 5'd0), 32'h0040_200c);
        repeat (3) @(posedge clk);
        es_fwd <= '{1'b1, 1'b1, 1'b0, 5'd9, 32'haaaa_0009};
        ms_fwd <= '{1'b1, 1'b1, 1'b0, 5'd7, 32'hbbbb_0007};
        issue(r_word(FN_JR, 5'd7, 5'd0, 5'd0, 5'd0), 32'h0040_2010);
        es_fwd <= '0;
        ms_fwd <= '0;
        ws_fwd <= '0;

        // execute not ready for a few cycles
        es_allowin <= 1'b0;
        fork
            begin
                repeat (5) @(posedge clk);
                es_allowin <= 1'b1;
            end
        join_none
        issue(kept[34], 32'h0040_3000);
        issue(kept[0], 32'h0040_3004);

        repeat (N_RAND) begin
            logic [31:0] r;
            @(posedge clk);
            r = $random(seed);
            if (es_allowin) begin
                fs_to_ds_valid <= r[2];
                fs_to_ds.pc <= $random(seed) & 32'hffff_fffc;
                if (r[7:4] == 4'd0) begin
                    fs_to_ds.inst <= $random(seed);
                end else begin
                    fs_to_ds.inst <= kept[$unsigned($random(seed)) % kept.size()] ^
                                     ($random(seed) & 32'h00e7_3800);
                end
                es_fwd <= rand_bus();
                ms_fwd <= rand_bus();
                ws_fwd <= rand_bus();
                // register writes land only while execute accepts
                rf_write <= '{we: r[8] && r[1:0] != 2'd0, addr: {2'b00, r[11:9]},
                              data: $random(seed)};
            end
            es_allowin <= r[1:0] != 2'd0;
        end
        @(posedge clk);
        es_allowin <= 1'b1;
        fs_to_ds_valid <= 1'b0;
        rf_write <= '0;
        repeat (5) @(posedge clk);

        if (dut0.props0.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "checker reported a failing assertion");
        end
    end

endmodule

`default_nettype wire

//--- tests/decode_properties.sv
`default_nettype none
`timescale 1ns/1ps

module decode_properties import decode_pkg::*; (
    input logic           clk,
    input logic           reset,
    input logic           fs_to_ds_valid,
    input fetch_bundle_t  fs_to_ds,
    input logic           ds_allowin,
    input logic           es_allowin,
    input fwd_bus_t       es_fwd,
    input fwd_bus_t       ms_fwd,
    input fwd_bus_t       ws_fwd,
    input rf_write_t      rf_write,
    input logic           ds_to_es_valid,
    input decode_bundle_t ds_to_es,
    input branch_bus_t    br
);

    int                fail_count = 0;
    logic [DATA_W-1:0] shadow [32];
    logic              held_valid;
    fetch_bundle_t     held;
    decode_bundle_t    prev_bundle;
    logic [31:0]       w;
    logic [5:0]        op;
    logic [5:0]        fn;
    reg_addr_t         rs;
    reg_addr_t         rt;
    reg_addr_t         rd;
    logic              r_alu, shift, jr, jalr, sys, brk, imm_alu, sw, cbr, jmp, jal, known;
    logic              exp_hazard;
    logic              exp_valid;
    logic              exp_taken;
    logic              exp_gr_we;
    logic [31:0]       pc4;
    logic [31:0]       exp_target;
    logic [63:0]       exp_ops;
    logic [54:0]       exp_dec;
    logic [54:0]       act_dec;
    logic [5:0]        exp_excp;

    function automatic logic [31:0] fwd_select(input reg_addr_t a, input logic [31:0] rf,
                                               input fwd_bus_t es, input fwd_bus_t ms,
                                               input fwd_bus_t ws);
        if (a == 5'd0) return 32'd0;
        if (es.valid && es.we && !es.is_load && es.addr == a) return es.value;
        if (ms.valid && ms.we && ms.addr == a) return ms.value;
        if (ws.valid && ws.we && ws.addr == a) return ws.value;
        return rf;
    endfunction

    // shadow copies of the register file and the held instruction
    always @(posedge clk) begin
        if (rf_write.we) begin
            shadow[rf_write.addr] <= rf_write.data;
        end
        if (reset) begin
            held_valid <= 1'b0;
        end else if (ds_allowin) begin
            held_valid <= fs_to_ds_valid;
        end
        if (fs_to_ds_valid && ds_allowin) begin
            held <= fs_to_ds;
        end
        prev_bundle <= ds_to_es;
    end

    always_comb begin
        w  = held.inst;
        op = w[31:26];
        fn = w[5:0];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        r_alu = op == 6'h00 && w[10:6] == 5'd0 && (fn inside {6'h21, 6'h23, 6'h20, 6'h22,
                6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07});
        shift = op == 6'h00 && rs == 5'd0 && (fn inside {6'h00, 6'h02, 6'h03});
        jr    = op == 6'h00 && w[10:6] == 5'd0 && fn == 6'h08 && rt == 5'd0 && rd == 5'd0;
        jalr  = op == 6'h00 && w[10:6] == 5'd0 && fn == 6'h09 && rt == 5'd0;
        sys   = op == 6'h00 && fn == 6'h0c;
        brk   = op == 6'h00 && fn == 6'h0d;
        imm_alu = (op inside {[6'h08:6'h0e], 6'h23}) || (op == 6'h0f && rs == 5'd0);
        sw    = op == 6'h2b;
        cbr   = (op inside {6'h04, 6'h05}) || ((op inside {6'h06, 6'h07}) && rt == 5'd0) ||
                (op == 6'h01 && rt <= 5'd1);
        jmp   = op == 6'h02;
        jal   = op == 6'h03;
        known = r_alu || shift || jr || jalr || sys || brk || imm_alu || sw || cbr || jmp || jal;
        exp_gr_we = (r_alu || shift || jalr || imm_alu || jal) && w != 32'd0;
        exp_dec = {held.pc, w[15:0], exp_gr_we, imm_alu || sw,
                   exp_gr_we ? (jal ? 5'd31 : (imm_alu ? rt : rd)) : 5'd0};
        act_dec = {ds_to_es.pc, ds_to_es.imm, ds_to_es.ctrl.gr_we, ds_to_es.ctrl.src2_is_imm,
                   exp_gr_we ? ds_to_es.ctrl.dest : 5'd0};
        exp_excp = !known ? {1'b1, 5'h0a} : sys ? {1'b1, 5'h08} : brk ? {1'b1, 5'h09} : 6'd0;
        exp_ops = {fwd_select(rs, shadow[rs], es_fwd, ms_fwd, ws_fwd),
                   fwd_select(rt, shadow[rt], es_fwd, ms_fwd, ws_fwd)};
        exp_hazard = es_fwd.valid && es_fwd.we && es_fwd.is_load &&
                     ((rs != 5'd0 && rs == es_fwd.addr) || (rt != 5'd0 && rt == es_fwd.addr));
        exp_valid = held_valid && !exp_hazard;
        // branch conditions on the forwarded operands
        case (1'b1)
            op == 6'h04: exp_taken = ds_to_es.rs_value == ds_to_es.rt_value;
            op == 6'h05: exp_taken = ds_to_es.rs_value != ds_to_es.rt_value;
            op == 6'h06: exp_taken = ds_to_es.rs_value[31] || ds_to_es.rs_value == 32'd0;
            op == 6'h07: exp_taken = !ds_to_es.rs_value[31] && ds_to_es.rs_value != 32'd0;
            op == 6'h01: exp_taken = ds_to_es.rs_value[31] ^ rt[0];
            default:     exp_taken = jmp || jal || jr || jalr;
        endcase
        exp_taken = exp_taken && (cbr || jmp || jal || jr || jalr);
        pc4 = held.pc + 32'd4;
        if (jr || jalr) begin
            exp_target = ds_to_es.rs_value;
        end else if (jmp || jal) begin
            exp_target = {pc4[31:28], w[25:0], 2'b00};
        end else begin
            exp_target = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
        end
    end

    a_reset: assert property (@(posedge clk) $fell(reset) |-> !ds_to_es_valid && !br.taken)
        else begin
            fail_count++;
            $error("error reset expected 00 actual %b%b", ds_to_es_valid, br.taken);
        end

    a_valid: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid == exp_valid)
        else begin
            fail_count++;
            $error("error stage_valid expected %b actual %b", exp_valid, ds_to_es_valid);
        end

    a_forward: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> {ds_to_es.rs_value, ds_to_es.rt_value} == exp_ops)
        else begin
            fail_count++;
            $error("error forwarding expected %h actual %h", exp_ops,
                   {ds_to_es.rs_value, ds_to_es.rt_value});
        end

    a_stall: assert property (@(posedge clk) disable iff (reset)
        held_valid && exp_hazard |-> !ds_to_es_valid && !ds_allowin)
        else begin
            fail_count++;
            $error("error load_use expected 00 actual %b%b", ds_to_es_valid, ds_allowin);
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid && ds_to_es == prev_bundle)
        else begin
            fail_count++;
            $error("error back_pressure expected %h actual %h", prev_bundle, ds_to_es);
        end

    a_branch: assert property (@(posedge clk) disable iff (reset)
        br.taken == (exp_valid && exp_taken) &&
        (!br.taken || br.target == exp_target))
        else begin
            fail_count++;
            $error("error branch expected %b %h actual %b %h", exp_valid && exp_taken,
                   exp_target, br.taken, br.target);
        end

    a_decode: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> act_dec == exp_dec &&
        {ds_to_es.ctrl.excp_valid, ds_to_es.ctrl.excp_code} == exp_excp)
        else begin
            fail_count++;
            $error("error decode expected %h %h actual %h %h", exp_dec, exp_excp, act_dec,
                   {ds_to_es.ctrl.excp_valid, ds_to_es.ctrl.excp_code});
        end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           fs_to_ds_valid,
    input  fetch_bundle_t  fs_to_ds,
    output logic           ds_allowin,
    input  logic           es_allowin,
    input  fwd_bus_t       es_fwd,
    input  fwd_bus_t       ms_fwd,
    input  fwd_bus_t       ws_fwd,
    input  rf_write_t      rf_write,
    output logic           ds_to_es_valid,
    output decode_bundle_t ds_to_es,
    output branch_bus_t    br
);

    logic              ds_valid;
    logic              ready;
    fetch_bundle_t     fs_to_ds_r;
    ctrl_t             ctrl;
    logic [DATA_W-1:0] rf_rdata1;
    logic [DATA_W-1:0] rf_rdata2;
    logic [DATA_W-1:0] rs_value;
    logic [DATA_W-1:0] rt_value;
    logic              load_hazard;

    // only stall source left is load-use
    assign ready          = !load_hazard;
    assign ds_allowin     = !ds_valid || (ready && es_allowin);
    assign ds_to_es_valid = ds_valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_r <= fs_to_ds;
        end
    end

    inst_decoder u_decoder (
        .inst (fs_to_ds_r.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (fs_to_ds_r.inst.r.rs),
        .raddr2 (fs_to_ds_r.inst.r.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_write)
    );

    operand_forward u_forward (
        .rs          (fs_to_ds_r.inst.r.rs),
        .rt          (fs_to_ds_r.inst.r.rt),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .es_fwd      (es_fwd),
        .ms_fwd      (ms_fwd),
        .ws_fwd      (ws_fwd),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .load_hazard (load_hazard)
    );

    // no redirect while operands are still pending
    branch_unit u_branch (
        .valid    (ds_valid && ready),
        .ctrl     (ctrl),
        .pc       (fs_to_ds_r.pc),
        .inst     (fs_to_ds_r.inst),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    assign ds_to_es = '{
        ctrl:     ctrl,
        imm:      fs_to_ds_r.inst.i.imm,
        rs_value: rs_value,
        rt_value: rt_value,
        pc:       fs_to_ds_r.pc
    };

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  logic              valid,
    input  ctrl_t             ctrl,
    input  logic [DATA_W-1:0] pc,
    input  inst_t             inst,
    input  logic [DATA_W-1:0] rs_value,
    input  logic [DATA_W-1:0] rt_value,
    output branch_bus_t       br
);

    logic [DATA_W-1:0] pc_plus4;
    logic              rs_eq_rt;
    logic              rs_lt_zero;
    logic              rs_gt_zero;
    logic              cond;

    assign pc_plus4   = pc + 32'd4;
    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_lt_zero = rs_value[DATA_W-1];
    assign rs_gt_zero = !rs_value[DATA_W-1] && (rs_value != '0);

    // jumps are unconditional
    assign cond = (ctrl.is_beq  &&  rs_eq_rt)   ||
                  (ctrl.is_bne  && !rs_eq_rt)   ||
                  (ctrl.is_bgez && !rs_lt_zero) ||
                  (ctrl.is_bgtz &&  rs_gt_zero) ||
                  (ctrl.is_blez && !rs_gt_zero) ||
                  (ctrl.is_bltz &&  rs_lt_zero) ||
                  ctrl.is_jump_imm || ctrl.is_jump_reg;

    assign br.taken = valid && cond;

    always_comb begin
        if (ctrl.is_jump_reg) begin
            br.target = rs_value;
        end else if (ctrl.is_jump_imm) begin
            // region of the delay slot
            br.target = {pc_plus4[31:28], inst.j.index, 2'b00};
        end else begin
            br.target = pc_plus4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
        end
    end

endmodule

`default_nettype wire

//--- src/operand_forward.sv
`default_nettype none
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
    input  reg_addr_t         rs,
    input  reg_addr_t         rt,
    input  logic [DATA_W-1:0] rf_rdata1,
    input  logic [DATA_W-1:0] rf_rdata2,
    input  fwd_bus_t          es_fwd,
    input  fwd_bus_t          ms_fwd,
    input  fwd_bus_t          ws_fwd,
    output logic [DATA_W-1:0] rs_value,
    output logic [DATA_W-1:0] rt_value,
    output logic              load_hazard
);

    logic es_load_pending;

    // newest stage wins, a load still in execute has no value yet
    function automatic logic [DATA_W-1:0] pick(
        input reg_addr_t         addr,
        input logic [DATA_W-1:0] rf_data,
        input fwd_bus_t          es,
        input fwd_bus_t          ms,
        input fwd_bus_t          ws
    );
        logic [DATA_W-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (es.valid && es.we && !es.is_load && (es.addr == addr)) begin
            value = es.value;
        end else if (ms.valid && ms.we && (ms.addr == addr)) begin
            value = ms.value;
        end else if (ws.valid && ws.we && (ws.addr == addr)) begin
            value = ws.value;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rs_value = pick(rs, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rt_value = pick(rt, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    assign es_load_pending = es_fwd.valid && es_fwd.we && es_fwd.is_load;

    // wait one cycle for the load data to reach memory stage
    assign load_hazard = es_load_pending &&
                         (((rs != '0) && (rs == es_fwd.addr)) ||
                          ((rt != '0) && (rt == es_fwd.addr)));

endmodule

`default_nettype wire

//--- src/regfile.sv
`default_nettype none
`timescale 1ns/1ps

module regfile import decode_pkg::*; (
    input  logic              clk,
    input  reg_addr_t         raddr1,
    input  reg_addr_t         raddr2,
    output logic [DATA_W-1:0] rdata1,
    output logic [DATA_W-1:0] rdata2,
    input  rf_write_t         wr
);

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // asynchronous read, r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  inst_t inst,
    output ctrl_t ctrl
);

    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       special;
    logic       regimm;
    logic       arith_r;
    logic       shift_r;
    logic       inst_addu, inst_subu, inst_add, inst_sub, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic       inst_addiu, inst_addi, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_j, inst_jal, inst_jr, inst_jalr;
    logic       inst_syscall, inst_break;
    logic       reserved;
    logic       dst_is_rt;

    // opcode through the jump view, fields through the other two
    assign op   = inst.j.op;
    assign func = inst.r.func;
    assign rs   = inst.r.rs;
    assign rt   = inst.i.rt;
    assign rd   = inst.r.rd;

    assign special = (op == OP_SPECIAL);
    assign regimm  = (op == OP_REGIMM);
    // register ops need sa zero, immediate shifts need rs zero
    assign arith_r = special && (inst.r.sa == '0);
    assign shift_r = special && (rs == '0);

    assign inst_addu  = arith_r && (func == FN_ADDU);
    assign inst_subu  = arith_r && (func == FN_SUBU);
    assign inst_add   = arith_r && (func == FN_ADD);
    assign inst_sub   = arith_r && (func == FN_SUB);
    assign inst_slt   = arith_r && (func == FN_SLT);
    assign inst_sltu  = arith_r && (func == FN_SLTU);
    assign inst_and   = arith_r && (func == FN_AND);
    assign inst_or    = arith_r && (func == FN_OR);
    assign inst_xor   = arith_r && (func == FN_XOR);
    assign inst_nor   = arith_r && (func == FN_NOR);
    assign inst_sllv  = arith_r && (func == FN_SLLV);
    assign inst_srlv  = arith_r && (func == FN_SRLV);
    assign inst_srav  = arith_r && (func == FN_SRAV);
    assign inst_sll   = shift_r && (func == FN_SLL);
    assign inst_srl   = shift_r && (func == FN_SRL);
    assign inst_sra   = shift_r && (func == FN_SRA);
    assign inst_jr    = arith_r && (func == FN_JR) && (rt == '0) && (rd == '0);
    assign inst_jalr  = arith_r && (func == FN_JALR) && (rt == '0);
    // code field of syscall and break is free
    assign inst_syscall = special && (func == FN_SYSCALL);
    assign inst_break   = special && (func == FN_BREAK);

    assign inst_addiu = (op == OP_ADDIU);
    assign inst_addi  = (op == OP_ADDI);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && (rs == '0);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_bgtz  = (op == OP_BGTZ) && (rt == '0);
    assign inst_blez  = (op == OP_BLEZ) && (rt == '0);
    assign inst_bgez  = regimm && (rt == RT_BGEZ);
    assign inst_bltz  = regimm && (rt == RT_BLTZ);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    assign reserved = !(inst_addu || inst_subu || inst_add || inst_sub || inst_slt ||
                        inst_sltu || inst_and || inst_or || inst_xor || inst_nor ||
                        inst_sll || inst_srl || inst_sra || inst_sllv || inst_srlv ||
                        inst_srav || inst_addiu || inst_addi || inst_slti || inst_sltiu ||
                        inst_andi || inst_ori || inst_xori || inst_lui || inst_lw ||
                        inst_sw || inst_beq || inst_bne || inst_bgez || inst_bgtz ||
                        inst_blez || inst_bltz || inst_j || inst_jal || inst_jr ||
                        inst_jalr || inst_syscall || inst_break);

    assign dst_is_rt = inst_addiu || inst_addi || inst_slti || inst_sltiu || inst_andi ||
                       inst_ori || inst_xori || inst_lui || inst_lw;

    always_comb begin
        ctrl = '0;
        // address add also serves loads, stores and link
        ctrl.alu_op[ALU_ADD]  = inst_addu || inst_addiu || inst_add || inst_addi ||
                                inst_lw || inst_sw || inst_jal || inst_jalr;
        ctrl.alu_op[ALU_SUB]  = inst_subu || inst_sub;
        ctrl.alu_op[ALU_SLT]  = inst_slt || inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu || inst_sltiu;
        ctrl.alu_op[ALU_AND]  = inst_and || inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or || inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor || inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll || inst_sllv;
        ctrl.alu_op[ALU_SRL]  = inst_srl || inst_srlv;
        ctrl.alu_op[ALU_SRA]  = inst_sra || inst_srav;
        ctrl.alu_op[ALU_LUI]  = inst_lui;
        ctrl.src1_is_sa   = inst_sll || inst_srl || inst_sra;
        ctrl.src1_is_pc   = inst_jal || inst_jalr;
        ctrl.src2_is_imm  = dst_is_rt || inst_sw;
        ctrl.src2_is_8    = inst_jal || inst_jalr;
        ctrl.zero_ext_imm = inst_andi || inst_ori || inst_xori;
        ctrl.load_op      = inst_lw;
        ctrl.mem_we       = inst_sw;
        ctrl.gr_we        = !(inst_sw || inst_beq || inst_bne || inst_bgez || inst_bgtz ||
                              inst_blez || inst_bltz || inst_j || inst_jr ||
                              inst_syscall || inst_break || reserved) && (inst != '0);
        ctrl.dest         = inst_jal ? 5'd31 : (dst_is_rt ? rt : rd);
        ctrl.is_beq       = inst_beq;
        ctrl.is_bne       = inst_bne;
        ctrl.is_bgez      = inst_bgez;
        ctrl.is_bgtz      = inst_bgtz;
        ctrl.is_blez      = inst_blez;
        ctrl.is_bltz      = inst_bltz;
        ctrl.is_jump_imm  = inst_j || inst_jal;
        ctrl.is_jump_reg  = inst_jr || inst_jalr;
        ctrl.excp_valid   = reserved || inst_syscall || inst_break;
        if (reserved) begin
            ctrl.excp_code = EXC_RI;
        end else if (inst_syscall) begin
            ctrl.excp_code = EXC_SYS;
        end else if (inst_break) begin
            ctrl.excp_code = EXC_BP;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int ALU_OP_W = 12;
    localparam int EXC_W    = 5;

    typedef logic [REG_AW-1:0] reg_addr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_SRA     = 6'h03;
    localparam logic [5:0] FN_SLLV    = 6'h04;
    localparam logic [5:0] FN_SRLV    = 6'h06;
    localparam logic [5:0] FN_SRAV    = 6'h07;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_JALR    = 6'h09;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_BREAK   = 6'h0d;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

    // rt field of REGIMM
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    localparam logic [EXC_W-1:0] EXC_SYS = 5'h08;
    localparam logic [EXC_W-1:0] EXC_BP  = 5'h09;
    localparam logic [EXC_W-1:0] EXC_RI  = 5'h0a;

    // one-hot positions inside alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] func;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } inst_j_t;

    // same word seen as register, immediate or jump format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        inst_t             inst;
    } fetch_bundle_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic              is_load;
        reg_addr_t         addr;
        logic [DATA_W-1:0] value;
    } fwd_bus_t;

    typedef struct packed {
        logic              we;
        reg_addr_t         addr;
        logic [DATA_W-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0] alu_op;
        logic                src1_is_sa;
        logic                src1_is_pc;
        logic                src2_is_imm;
        logic                src2_is_8;
        logic                zero_ext_imm;
        logic                load_op;
        logic                mem_we;
        logic                gr_we;
        reg_addr_t           dest;
        logic                is_beq;
        logic                is_bne;
        logic                is_bgez;
        logic                is_bgtz;
        logic                is_blez;
        logic                is_bltz;
        logic                is_jump_imm;
        logic                is_jump_reg;
        logic                excp_valid;
        logic [EXC_W-1:0]    excp_code;
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [15:0]       imm;
        logic [DATA_W-1:0] rs_value;
        logic [DATA_W-1:0] rt_value;
        logic [DATA_W-1:0] pc;
    } decode_bundle_t;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } branch_bus_t;

endpackage

`default_nettype wire
